/* Makefile */
# Verilator build for the cartridge loader testbench

VERILATOR ?= verilator
TOP       ?= tb_cart_loader
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv) $(wildcard test/*.sv test/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
+incdir+test
rtl/loader_pkg.sv
rtl/download_decoder.sv
rtl/rom_writer.sv
rtl/cart_geometry.sv
rtl/cheat_assembler.sv
rtl/cart_loader.sv
test/tb_cart_loader.sv

/* rtl/cart_geometry.sv */
// Cartridge geometry
// Tracks the address masks of the loaded image, with and without
// a 512-byte header, the Game Gear flag, and maps ROM read addresses
module cart_geometry import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  dl_beat_t  beat,
	input  logic      rd,
	input  rom_addr_t rd_addr,
	output rom_addr_t mapped_addr,
	output logic      mapped_valid,
	output logic      game_gear
);

	rom_addr_t mask;
	rom_addr_t mask512;
	rom_addr_t image_size;
	rom_addr_t mapped_q;
	logic      has_header;
	logic      gg_q;
	logic      valid_q;
	logic      cart_beat;

	assign cart_beat = (beat.kind == beat_cart);
	// Image byte count is the last address plus one
	assign image_size = beat.addr[21:0] + 22'd1;

	// ==============================
	// Mask tracking
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mask       <= '0;
			mask512    <= '0;
			has_header <= 1'b0;
			gg_q       <= 1'b0;
			valid_q    <= 1'b0;
		end else begin
			if (cart_beat) begin
				mask <= beat.zero_addr ? '0 : (mask | beat.addr[21:0]);
				// Header mask restarts at the first byte past the header
				if (beat.addr == host_addr_t'(HEADER_SIZE))
					mask512 <= '0;
				else
					mask512 <= mask512 | (beat.addr[21:0] - HEADER_SIZE);
				gg_q <= beat.game_gear;
			end
			if (beat.stop)
				has_header <= image_size[9];
			valid_q <= rd;
		end
	end

	// ==============================
	// Read mapping
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rd) begin
			if (has_header)
				mapped_q <= (rd_addr + HEADER_SIZE) & mask512;
			else
				mapped_q <= rd_addr & mask;
		end
	end

	assign mapped_addr  = mapped_q;
	assign mapped_valid = valid_q;
	assign game_gear    = gg_q;

endmodule

/* rtl/cart_loader.sv */
// Cartridge loader top
// Host beats pass through the decoder, then fan out to the ROM
// writer, the geometry tracker and the cheat assembler
module cart_loader import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  host_beat_t  host,
	output logic        ioctl_wait,
	output rom_write_t  rom_wr,
	input  logic        mem_ack,
	input  logic        rd,
	input  rom_addr_t   rd_addr,
	output rom_addr_t   mapped_addr,
	output logic        mapped_valid,
	output logic        game_gear,
	output logic        cart_loading,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_clear
);

	dl_beat_t beat;

	download_decoder u_decoder (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.host         (host),
		.beat         (beat),
		.cart_loading (cart_loading)
	);

	rom_writer u_rom_writer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.beat       (beat),
		.mem_ack    (mem_ack),
		.rom_wr     (rom_wr),
		.ioctl_wait (ioctl_wait)
	);

	cart_geometry u_geometry (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.beat         (beat),
		.rd           (rd),
		.rd_addr      (rd_addr),
		.mapped_addr  (mapped_addr),
		.mapped_valid (mapped_valid),
		.game_gear    (game_gear)
	);

	cheat_assembler u_cheats (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.beat        (beat),
		.code        (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

/* rtl/cheat_assembler.sv */
// Cheat assembler
// Gathers the sixteen bytes of a cheat download into one code
// and pulses valid once the last byte is in
module cheat_assembler import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_beat_t    beat,
	output cheat_code_t code,
	output logic        cheat_valid,
	output logic        cheat_clear
);

	cheat_code_t code_q;
	logic [3:0]  slot;
	logic        code_beat;
	logic        valid_q;
	logic        clear_q;

	assign code_beat = (beat.kind == beat_code);
	// Groups run flags, address, compare, replace from the top down,
	// lane 0 lowest inside a group
	assign slot = {~beat.addr[3:2], beat.addr[1:0]};

	always_ff @(posedge clk_sys) begin
		if (code_beat)
			code_q[{slot, 3'b000} +: 8] <= beat.data;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_q <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			valid_q <= code_beat && (beat.addr[3:0] == 4'(CHEAT_BEATS - 1));
			// Any download restarting at zero drops old codes
			clear_q <= (beat.kind != beat_none) && beat.zero_addr;
		end
	end

	assign code        = code_q;
	assign cheat_valid = valid_q;
	assign cheat_clear = clear_q;

endmodule

/* rtl/download_decoder.sv */
// Download decoder
// Registers host writes, tells cartridge bytes from cheat bytes
// and marks the start and end of a cartridge download
module download_decoder import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  host_beat_t host,
	output dl_beat_t   beat,
	output logic       cart_loading
);

	logic       code_index;
	logic       cart_dl;
	logic       cart_dl_prev;
	beat_kind_t kind_q;
	logic       start_q;
	logic       stop_q;
	host_addr_t addr_q;
	byte_t      data_q;
	logic       gg_q;
	logic       zero_q;

	assign code_index = (host.index == CODE_INDEX);
	// Every other index loads a cartridge image
	assign cart_dl = host.download & ~code_index;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kind_q       <= beat_none;
			start_q      <= 1'b0;
			stop_q       <= 1'b0;
			cart_dl_prev <= 1'b0;
		end else begin
			cart_dl_prev <= cart_dl;
			start_q      <= cart_dl & ~cart_dl_prev;
			stop_q       <= ~cart_dl & cart_dl_prev;
			if (host.wr && host.download)
				kind_q <= code_index ? beat_code : beat_cart;
			else
				kind_q <= beat_none;
		end
	end

	// Held between writes so the end pulse still sees the final address
	always_ff @(posedge clk_sys) begin
		if (host.wr) begin
			addr_q <= host.addr;
			data_q <= host.data;
			gg_q   <= (host.index[4:0] == GG_INDEX_LOW);
			zero_q <= (host.addr == '0);
		end
	end

	assign beat = '{kind: kind_q, addr: addr_q, data: data_q, start: start_q,
		stop: stop_q, game_gear: gg_q, zero_addr: zero_q};
	assign cart_loading = cart_dl_prev;

endmodule

/* rtl/loader_pkg.sv */
// Cartridge loader package
// Widths, host and pipeline beat structs, and the constants
// shared by the stages of the cartridge loading path
package loader_pkg;

	// ==============================
	// Widths
	// ==============================
	typedef logic [24:0]  host_addr_t;
	typedef logic [21:0]  rom_addr_t;
	typedef logic [7:0]   byte_t;
	typedef logic [7:0]   dl_index_t;
	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	typedef logic [127:0] cheat_code_t;

	// Stage one classification of a host write
	typedef enum logic [1:0] {
		beat_none,
		beat_cart,
		beat_code
	} beat_kind_t;

	// ==============================
	// Beat structs
	// ==============================
	typedef struct packed {
		logic       download;
		logic       wr;
		host_addr_t addr;
		byte_t      data;
		dl_index_t  index;
	} host_beat_t;

	// Start and stop mark the rise and fall of a cartridge download
	typedef struct packed {
		beat_kind_t kind;
		host_addr_t addr;
		byte_t      data;
		logic       start;
		logic       stop;
		logic       game_gear;
		logic       zero_addr;
	} dl_beat_t;

	typedef struct packed {
		rom_addr_t addr;
		byte_t     data;
		logic      req;
	} rom_write_t;

	// ==============================
	// Constants
	// ==============================
	localparam dl_index_t  CODE_INDEX   = 8'hFF;
	localparam logic [4:0] GG_INDEX_LOW = 5'd2;
	localparam rom_addr_t  HEADER_SIZE  = 22'd512;
	localparam int         CHEAT_BEATS  = 16;

endpackage

/* rtl/rom_writer.sv */
// ROM writer
// Writes cartridge bytes to external ROM memory with a toggle
// request and acknowledge, holding the host off until each write lands
module rom_writer import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  dl_beat_t   beat,
	input  logic       mem_ack,
	output rom_write_t rom_wr,
	output logic       ioctl_wait
);

	rom_addr_t addr_q;
	byte_t     data_q;
	logic      req_q;
	logic      wait_q;
	logic      cart_beat;

	assign cart_beat = (beat.kind == beat_cart);

	// ==============================
	// Request and wait
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_q  <= 1'b0;
			wait_q <= 1'b0;
			addr_q <= '0;
		end else begin
			if (cart_beat) begin
				req_q  <= ~req_q;
				wait_q <= 1'b1;
			end else if (wait_q && (req_q == mem_ack)) begin
				// Memory took the byte and the address steps on
				wait_q <= 1'b0;
				addr_q <= addr_q + 22'd1;
			end
			// New image always starts at address zero
			if (beat.start)
				addr_q <= '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_beat)
			data_q <= beat.data;
	end

	assign rom_wr     = '{addr: addr_q, data: data_q, req: req_q};
	assign ioctl_wait = wait_q;

endmodule

/* test/tb_reference.svh */
// Reference models for the cartridge loader testbench
// Expected read mapping, cheat code layout, Game Gear flag and the
// xorshift random generator
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// Images whose size has bit 9 set carry a 512-byte header
function automatic rom_addr_t expected_mapped(input rom_addr_t addr, input int image_size);
	int        body;
	rom_addr_t offset;
	body   = image_size[9] ? image_size - 512 : image_size;
	offset = image_size[9] ? 22'd512 : 22'd0;
	return (addr + offset) & rom_addr_t'(body - 1);
endfunction

// Byte n goes to group n/4 from the top, lane n%4 from the bottom
function automatic cheat_code_t expected_cheat(input byte_t bytes [16]);
	cheat_code_t code;
	code = '0;
	for (int n = 0; n < 16; n++)
		code[(3 - n / 4) * 32 + (n % 4) * 8 +: 8] = bytes[n];
	return code;
endfunction

function automatic logic expected_gg(input dl_index_t index);
	return index[4:0] == 5'd2;
endfunction

`endif

/* test/tb_cart_loader.sv */
// Cartridge loader testbench
// Loads cartridge images and a cheat code through the host port,
// models the ROM memory and checks writes, masks and cheats
module tb_cart_loader import loader_pkg::*; ();

	`include "tb_reference.svh"

	localparam int TIMEOUT = 200;

	logic        clk_sys;
	logic        reset;
	host_beat_t  host;
	logic        ioctl_wait;
	rom_write_t  rom_wr;
	logic        mem_ack;
	logic        rd;
	rom_addr_t   rd_addr;
	rom_addr_t   mapped_addr;
	logic        mapped_valid;
	logic        game_gear;
	logic        cart_loading;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        cheat_clear;

	logic [31:0] rng_state = 32'h15142014;
	rom_addr_t   got_addr [$];
	byte_t       got_data [$];
	byte_t       sent [$];
	cheat_code_t exp_code;
	int          valid_count;
	int          clear_count;

	cart_loader DUT (.*);

	always #10 clk_sys = ~clk_sys;

	// ==============================
	// ROM memory model
	// ==============================
	initial begin : memory_model
		int delay;
		mem_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!reset && rom_wr.req != mem_ack) begin
				got_addr.push_back(rom_wr.addr);
				got_data.push_back(rom_wr.data);
				rng_state = xorshift32(rng_state);
				delay = rng_state % 6;
				repeat (delay) @(negedge clk_sys);
				mem_ack = rom_wr.req;
			end
		end
	end

	// Cheat output monitor
	always @(negedge clk_sys) begin
		if (!reset && cheat_valid) begin
			valid_count++;
			assert (cheat_code == exp_code) else begin
				$display("Testbench failed");
				$display("mismatch at %0t: cheat code %h, expected %h", $time, cheat_code, exp_code);
				$fatal(1);
			end
		end
		if (!reset && cheat_clear)
			clear_count++;
	end

	// ==============================
	// Host tasks
	// ==============================
	task automatic wait_ready();
		int t;
		for (t = 0; t < TIMEOUT && ioctl_wait; t++)
			@(negedge clk_sys);
		assert (!ioctl_wait) else begin
			$display("Testbench failed");
			$display("timeout at %0t waiting for ioctl_wait to fall", $time);
			$fatal(1);
		end
	endtask

	task automatic write_byte(input host_addr_t addr, input byte_t data);
		wait_ready();
		host.wr   = 1'b1;
		host.addr = addr;
		host.data = data;
		@(negedge clk_sys);
		host.wr = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic load_cart(input dl_index_t index, input int size);
		sent.delete();
		got_addr.delete();
		got_data.delete();
		host.download = 1'b1;
		host.index    = index;
		repeat (3) @(negedge clk_sys);
		assert (cart_loading) else begin
			$display("Testbench failed");
			$display("mismatch at %0t: cart_loading low during download", $time);
			$fatal(1);
		end
		for (int i = 0; i < size; i++) begin
			rng_state = xorshift32(rng_state);
			sent.push_back(rng_state[7:0]);
			write_byte(host_addr_t'(i), rng_state[7:0]);
		end
		wait_ready();
		host.download = 1'b0;
		repeat (3) @(negedge clk_sys);
		assert (!cart_loading && got_addr.size() == size) else begin
			$display("Testbench failed");
			$display("mismatch at %0t: %0d bytes written, expected %0d", $time,
				got_addr.size(), size);
			$fatal(1);
		end
		for (int i = 0; i < size; i++) begin
			assert (got_addr[i] == rom_addr_t'(i) && got_data[i] == sent[i]) else begin
				$display("Testbench failed");
				$display("mismatch at %0t: write %0d at %h data %h, expected data %h", $time,
					i, got_addr[i], got_data[i], sent[i]);
				$fatal(1);
			end
		end
		assert (game_gear == expected_gg(index)) else begin
			$display("Testbench failed");
			$display("mismatch at %0t: game_gear %b for index %h", $time, game_gear, index);
			$fatal(1);
		end
	endtask

	task automatic check_reads(input int image_size, input int count);
		rom_addr_t addr;
		for (int i = 0; i < count; i++) begin
			rng_state = xorshift32(rng_state);
			addr    = rng_state[21:0];
			rd      = 1'b1;
			rd_addr = addr;
			@(negedge clk_sys);
			rd = 1'b0;
			assert (mapped_valid && mapped_addr == expected_mapped(addr, image_size)) else begin
				$display("Testbench failed");
				$display("mismatch at %0t: read %h gave %h valid %b, expected %h", $time, addr,
					mapped_addr, mapped_valid, expected_mapped(addr, image_size));
				$fatal(1);
			end
			@(negedge clk_sys);
			assert (!mapped_valid) else begin
				$display("Testbench failed");
				$display("mismatch at %0t: mapped_valid high past one cycle", $time);
				$fatal(1);
			end
		end
	endtask

	task automatic load_cheat();
		byte_t bytes [16];
		int t;
		valid_count = 0;
		clear_count = 0;
		for (int n = 0; n < 16; n++) begin
			rng_state = xorshift32(rng_state);
			bytes[n] = rng_state[7:0];
		end
		exp_code      = expected_cheat(bytes);
		host.download = 1'b1;
		host.index    = CODE_INDEX;
		@(negedge clk_sys);
		for (int n = 0; n < 16; n++)
			write_byte(host_addr_t'(n), bytes[n]);
		for (t = 0; t < TIMEOUT && valid_count == 0; t++)
			@(negedge clk_sys);
		host.download = 1'b0;
		repeat (4) @(negedge clk_sys);
		assert (valid_count == 1 && clear_count == 1 && !cart_loading) else begin
			$display("Testbench failed");
			$display("mismatch at %0t: %0d valid pulses, %0d clear pulses", $time,
				valid_count, clear_count);
			$fatal(1);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		host        = '0;
		rd          = 1'b0;
		rd_addr     = '0;
		exp_code    = '0;
		valid_count = 0;
		clear_count = 0;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		assert (!ioctl_wait && !cheat_valid && !mapped_valid && !cart_loading) else begin
			$display("Testbench failed");
			$display("mismatch at %0t: outputs not idle after reset", $time);
			$fatal(1);
		end

		load_cart(8'h01, 2048);
		check_reads(2048, 40);
		load_cart(8'h22, 1024 + 512);
		check_reads(1024 + 512, 40);
		load_cheat();
		load_cart(8'h03, 256);
		check_reads(256, 20);

		$display("Testbench passed");
		$finish;
	end

endmodule
